//--- pianoTiles.f
+incdir+verilog
verilog/pianoTilesPkg.sv
verilog/gameControl.sv
verilog/tileLane.sv
verilog/pixelMixer.sv
verilog/pianoTilesTop.sv
verification/pianoTiles_chk.sv
verification/pianoTilesTb.sv

//--- verification/pianoTilesTb.sv
`timescale 1ns/1ns
`default_nettype none

`include "pianoTiles_params.svh"

module pianoTilesTb;

    localparam int stepDivTb = 4; // fast tile movement
    localparam int wrapCycles = 501 * stepDivTb + 20; // lane 0 tile all the way down
    localparam int randomCycles = 3000;
    localparam int plannedCycles = 200 + wrapCycles + randomCycles;
    localparam int cycleLimit = 2 * plannedCycles;

    logic clk_d;
    logic rst;
    pianoTilesPkg::coordT pixelX;
    pianoTilesPkg::coordT pixelY;
    logic active;
    pianoTilesPkg::laneMaskT laneEnable;
    pianoTilesPkg::laneMaskT buttons;
    logic startButton;
    logic stageChange;
    logic [3:0] red;
    logic [3:0] green;
    logic [3:0] blue;
    pianoTilesPkg::scoreT score;
    pianoTilesPkg::gameStateT gameState;

    // reference model state
    pianoTilesPkg::gameStateT mState;
    int mScore;
    logic mHit;
    int mTop [0:`PT_LANES-1];
    int mCnt [0:`PT_LANES-1];
    pianoTilesPkg::rgbT expColour; // registered colour expected after the last edge
    logic modelReady = 1'b0;

    string testName = "none";
    int errorCount = 0;
    int cycleCount = 0;
    integer seed;

    pianoTilesTop #(.stepDiv(stepDivTb)) pianoTilesTop_i
    (
        .clk_d(clk_d),
        .rst(rst),
        .pixelX(pixelX),
        .pixelY(pixelY),
        .active(active),
        .laneEnable(laneEnable),
        .buttons(buttons),
        .startButton(startButton),
        .stageChange(stageChange),
        .red(red),
        .green(green),
        .blue(blue),
        .score(score),
        .gameState(gameState)
    );

    initial
    begin
        clk_d = 1'b0;
        forever #50 clk_d = ~clk_d;
    end

    function automatic logic modelInTile(input int lane, input int x, input int y,
                                         input logic en, input int top);
        return en && (x > `PT_LANE_X_LO(lane)) && (x < `PT_LANE_X_HI(lane))
            && (y > top) && (y < top + `PT_TILE_HEIGHT);
    endfunction

    function automatic pianoTilesPkg::rgbT laneColourOf(input int lane);
        case (lane)
            0: return `PT_COL_LANE0;
            1: return `PT_COL_LANE1;
            2: return `PT_COL_LANE2;
            default: return `PT_COL_LANE3;
        endcase
    endfunction

    // expected mixer colour for one pixel
    function automatic pianoTilesPkg::rgbT expectedColour(input int x, input logic act,
        input pianoTilesPkg::gameStateT st, input pianoTilesPkg::laneMaskT mask,
        input logic hit);
        pianoTilesPkg::rgbT c;
        c = `PT_COL_BLACK;
        if (act && st == pianoTilesPkg::stTitle)
            c = `PT_COL_TITLE;
        else if (act && st == pianoTilesPkg::stOver)
            c = `PT_COL_OVER;
        else if (act && st == pianoTilesPkg::stPlaying)
        begin
            for (int n = 0; n < `PT_LANES; n++)
                if (mask[n] && !hit)
                    c = laneColourOf(n); // a hit tile stays black
            for (int n = 0; n < `PT_LANES - 1; n++)
                if (mask == 0 && x > `PT_LANE_X_HI(n) && x < `PT_LANE_X_LO(n + 1))
                    c = `PT_COL_DIVIDER;
        end
        return c;
    endfunction

    // model advances on the inputs the DUT samples at this edge
    always @(posedge clk_d)
    begin
        pianoTilesPkg::laneMaskT mask;
        if (rst)
        begin
            mState = pianoTilesPkg::stTitle;
            mScore = 0;
            mHit = 1'b0;
            expColour = `PT_COL_BLACK;
            for (int l = 0; l < `PT_LANES; l++)
            begin
                mTop[l] = 0;
                mCnt[l] = 0;
            end
        end
        else
        begin
            for (int l = 0; l < `PT_LANES; l++)
                mask[l] = modelInTile(l, pixelX, pixelY, laneEnable[l], mTop[l]);
            expColour = expectedColour(pixelX, active, mState, mask, mHit);
            for (int l = 0; l < `PT_LANES && mState == pianoTilesPkg::stPlaying; l++)
            begin
                if (mTop[l] + `PT_TILE_HEIGHT > `PT_SCREEN_BOTTOM)
                begin
                    mTop[l] = 0; // wrap
                    mCnt[l] = 0;
                end
                else if (mask[l] && mCnt[l] == stepDivTb)
                begin
                    mTop[l]++;
                    mCnt[l] = 1;
                end
                else if (mask[l])
                    mCnt[l]++;
                if (stageChange)
                    mTop[l] = 0;
            end
            case (mState)
                pianoTilesPkg::stTitle:
                    if (startButton)
                    begin
                        mScore = 0;
                        mState = pianoTilesPkg::stPlaying;
                    end
                pianoTilesPkg::stPlaying:
                begin
                    if (mask != 0 && !mHit && (buttons & mask) != 0)
                    begin
                        mScore = (mScore + 1) % 1024;
                        mHit = 1'b1;
                    end
                    else if (mask != 0 && !mHit && (buttons & ~mask) != 0)
                        mState = pianoTilesPkg::stOver; // wrong lane
                    if (stageChange)
                        mHit = 1'b0;
                end
                default:
                    if (buttons[0] && buttons[1])
                        mState = pianoTilesPkg::stTitle;
            endcase
        end
        modelReady = 1'b1;
    end

    task automatic check(input string what, input int expected, input int actual);
        if (expected != actual)
        begin
            errorCount++;
            $display("FAILED %s %s: expected %0h, actual %0h", testName, what, expected,
                     actual);
            $display("SIMULATION FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // outputs settle well before the falling edge
    always @(negedge clk_d)
    begin
        if (modelReady)
        begin
            check("colour", expColour, {red, green, blue});
            check("score", mScore, score);
            check("state", mState, gameState);
            check("assertions", 0, pianoTilesTop_i.chk_i.assertFails);
        end
    end

    always @(posedge clk_d)
    begin
        cycleCount++;
        if (cycleCount > cycleLimit)
        begin
            $display("timeout: the run went past %0d cycles without finishing", cycleLimit);
            $display("SIMULATION FAILED");
            $fatal(1, "timeout");
        end
    end

    task automatic drive(input int x, input int y, input logic act,
                         input pianoTilesPkg::laneMaskT en, input pianoTilesPkg::laneMaskT btn,
                         input logic start, input logic stage);
        @(posedge clk_d);
        pixelX <= pianoTilesPkg::coordT'(x);
        pixelY <= pianoTilesPkg::coordT'(y);
        active <= act;
        laneEnable <= en;
        buttons <= btn;
        startButton <= start;
        stageChange <= stage;
    endtask

    task automatic scan(input int x, input int y);
        drive(x, y, 1'b1, 4'hF, 4'h0, 1'b0, 1'b0); // plain visible pixel, no buttons
    endtask

    function automatic int tileX(input int lane);
        return `PT_LANE_X_LO(lane) + 78; // lane centre
    endfunction

    // read only after a falling edge so the model has settled
    function automatic int tileY(input int lane);
        return mTop[lane] + 50;
    endfunction

    function automatic int randBelow(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    task automatic randomCycle();
        int lane;
        int x;
        int y;
        pianoTilesPkg::laneMaskT en;
        pianoTilesPkg::laneMaskT btn;
        lane = randBelow(`PT_LANES);
        x = randBelow(640);
        y = randBelow(600);
        if (randBelow(2) == 1)
        begin
            x = tileX(lane); // aim inside a tile half the time
            y = mTop[lane] + 1 + randBelow(99);
        end
        en = (randBelow(4) == 0) ? pianoTilesPkg::laneMaskT'(randBelow(16)) : 4'hF;
        btn = (randBelow(12) == 0) ? pianoTilesPkg::laneMaskT'(randBelow(16)) : 4'h0;
        drive(x, y, randBelow(8) != 0, en, btn, randBelow(40) == 0, randBelow(50) == 0);
    endtask

    initial
    begin
        int i;
        seed = 32'hf986_8901;
        rst = 1'b1;
        pixelX = '0;
        pixelY = '0;
        active = 1'b0;
        laneEnable = 4'h0;
        buttons = 4'h0;
        startButton = 1'b0;
        stageChange = 1'b0;
        repeat (3) @(posedge clk_d);
        rst <= 1'b0;

        testName = "reset";
        drive(0, 0, 1'b0, 4'hF, 4'h0, 1'b0, 1'b0);
        @(negedge clk_d);
        check("state after reset", pianoTilesPkg::stTitle, gameState);
        scan(300, 300); // title colour
        scan(10, 10);
        drive(300, 300, 1'b1, 4'hF, 4'h0, 1'b1, 1'b0);
        scan(300, 300);
        @(negedge clk_d);
        check("state after start", pianoTilesPkg::stPlaying, gameState);

        testName = "colours";
        for (i = 0; i < `PT_LANES; i++)
        begin
            @(negedge clk_d);
            scan(tileX(i), tileY(i));
        end
        scan(159, 300); // divider gaps
        scan(320, 300);
        scan(481, 300);
        scan(157, 300); // lane edge is neither lane nor gap
        scan(50, 300);
        drive(tileX(0), 30, 1'b0, 4'hF, 4'h0, 1'b0, 1'b0); // blanking

        testName = "movement";
        for (i = 0; i < 4 * stepDivTb + 1; i++)
        begin
            @(negedge clk_d);
            scan(tileX(1), tileY(1));
        end
        @(negedge clk_d);
        scan(tileX(1), mTop[1] + 1); // first line inside the tile
        @(negedge clk_d);
        scan(tileX(1), mTop[1]); // top line itself is outside

        testName = "wrap";
        i = 0;
        @(negedge clk_d);
        while (mTop[0] <= 500 && i < wrapCycles)
        begin
            scan(tileX(0), tileY(0));
            @(negedge clk_d);
            i++;
        end
        scan(300, 300);
        scan(tileX(0), 1);
        scan(300, 300);
        @(negedge clk_d);
        check("colour after wrap", `PT_COL_LANE0, {red, green, blue});

        testName = "stage";
        drive(300, 300, 1'b1, 4'hF, 4'h0, 1'b0, 1'b1);
        for (i = 0; i < `PT_LANES; i++)
            scan(tileX(i), 1);

        testName = "hit";
        drive(tileX(2), 50, 1'b1, 4'hF, 4'b0100, 1'b0, 1'b0);
        drive(tileX(2), 50, 1'b1, 4'hF, 4'b0100, 1'b0, 1'b0); // same stage, no score
        scan(tileX(2), 50); // hit tile shows black
        drive(300, 300, 1'b1, 4'hF, 4'h0, 1'b0, 1'b1);
        drive(tileX(2), 50, 1'b1, 4'hF, 4'b0100, 1'b0, 1'b0);
        scan(300, 300);
        @(negedge clk_d);
        check("score after two stages", 2, score);

        testName = "wrong";
        drive(300, 300, 1'b1, 4'hF, 4'h0, 1'b0, 1'b1);
        drive(tileX(3), 50, 1'b1, 4'hF, 4'b0001, 1'b0, 1'b0);
        scan(300, 300);
        scan(300, 300);
        @(negedge clk_d);
        check("state after wrong press", pianoTilesPkg::stOver, gameState);
        check("game over colour", `PT_COL_OVER, {red, green, blue});
        drive(300, 300, 1'b1, 4'hF, 4'b0011, 1'b0, 1'b0);
        scan(300, 300);
        @(negedge clk_d);
        check("state after return", pianoTilesPkg::stTitle, gameState);

        testName = "random";
        for (i = 0; i < randomCycles; i++)
        begin
            @(negedge clk_d);
            randomCycle();
        end
        scan(300, 300);
        @(negedge clk_d);

        if (errorCount == 0)
        begin
            $display("SIMULATION PASSED");
            $finish;
        end
        else
        begin
            $display("SIMULATION FAILED");
            $fatal(1, "%0d checks failed", errorCount);
        end
    end

endmodule

`default_nettype wire

//--- verification/pianoTiles_chk.sv
`timescale 1ns/1ns
`default_nettype none

module pianoTilesChk
(
    input wire logic clk_d,
    input wire logic rst,
    input wire logic active,
    input wire logic [3:0] red,
    input wire logic [3:0] green,
    input wire logic [3:0] blue,
    input wire pianoTilesPkg::scoreT score,
    input wire pianoTilesPkg::gameStateT gameState
);

    int assertFails = 0; // failed assertion count

    // one hit per clock at most, a drop to zero on a new game is fine
    scoreStep: assert property (@(posedge clk_d) disable iff (rst)
        int'(score) <= int'($past(score)) + 1)
    else
    begin
        $error("score rose by more than one in a single clock");
        assertFails++;
    end

    stateCode: assert property (@(posedge clk_d) disable iff (rst) gameState != 2'd3)
    else
    begin
        $error("gameState holds the unused code");
        assertFails++;
    end

    // mixer output is one clock behind the blanking input
    blankBlack: assert property (@(posedge clk_d) disable iff (rst)
        !active |=> ({red, green, blue} == 12'h000))
    else
    begin
        $error("colour not black one clock after blanking");
        assertFails++;
    end

endmodule

bind pianoTilesTop pianoTilesChk chk_i
(
    .clk_d(clk_d),
    .rst(rst),
    .active(active),
    .red(red),
    .green(green),
    .blue(blue),
    .score(score),
    .gameState(gameState)
);

`default_nettype wire

//--- verilog/gameControl.sv
`timescale 1ns/1ns
`default_nettype none

module gameControl
(
    input wire logic clk_d,
    input wire logic rst,
    input wire logic startButton,
    input wire logic stageChange, // one cycle pulse at each new stage
    input wire pianoTilesPkg::laneMaskT buttons,
    input wire pianoTilesPkg::laneMaskT inTile, // which lane's tile holds the current pixel
    output pianoTilesPkg::gameStateT gameState,
    output pianoTilesPkg::scoreT score,
    output logic tileHit // a tile was already hit this stage
);

    // judgement terms, all from the current pixel and buttons
    logic anyInTile;
    logic judgeOpen;
    logic correctPress;
    logic wrongPress;
    logic returnToTitle;

    assign anyInTile = |inTile;
    assign judgeOpen = anyInTile && !tileHit; // only one hit counts per stage

    // lanes never overlap so at most one inTile bit is set
    assign correctPress = |(buttons & inTile);

    // any button on a lane other than the one under the scan
    assign wrongPress = |(buttons & ~inTile);

    // both left buttons together leave the game over screen
    assign returnToTitle = buttons[0] && buttons[1];

    always_ff @(posedge clk_d)
    begin
        if (rst)
        begin
            gameState <= pianoTilesPkg::stTitle;
            score <= '0;
            tileHit <= 1'b0;
        end
        else
        begin
            case (gameState)
                pianoTilesPkg::stTitle:
                begin
                    if (startButton)
                    begin
                        score <= '0; // new game
                        gameState <= pianoTilesPkg::stPlaying;
                    end
                end

                pianoTilesPkg::stPlaying:
                begin
                    if (judgeOpen)
                    begin
                        // a correct press wins over a wrong one in the same clock
                        if (correctPress)
                        begin
                            score <= score + pianoTilesPkg::scoreT'(1);
                            tileHit <= 1'b1;
                        end
                        else if (wrongPress)
                        begin
                            gameState <= pianoTilesPkg::stOver;
                        end
                    end

                    // presses with no tile under the scan fall through untouched

                    if (stageChange)
                    begin
                        tileHit <= 1'b0; // next stage allows another hit
                    end
                end

                pianoTilesPkg::stOver:
                begin
                    if (returnToTitle)
                    begin
                        gameState <= pianoTilesPkg::stTitle; // score stays visible until start
                    end
                end

                default:
                begin
                    gameState <= pianoTilesPkg::stTitle; // recover from the unused code
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/pianoTilesPkg.sv
`default_nettype none

`include "pianoTiles_params.svh"

package pianoTilesPkg;

    // game sequencer states, code 2'd3 is never entered
    typedef enum logic [1:0]
    {
        stTitle = 2'd0,
        stPlaying = 2'd1,
        stOver = 2'd2
    } gameStateT;

    // pixel coordinate, also used for tile positions
    typedef logic [`PT_COORD_W-1:0] coordT;

    typedef logic [`PT_SCORE_W-1:0] scoreT; // hit count

    // one bit per lane, lane 0 in bit 0
    typedef logic [`PT_LANES-1:0] laneMaskT;

    // red in [11:8], green in [7:4], blue in [3:0]
    typedef logic [11:0] rgbT;

endpackage

`default_nettype wire

//--- verilog/pianoTilesTop.sv
`timescale 1ns/1ns
`default_nettype none

`include "pianoTiles_params.svh"

module pianoTilesTop
#(
    parameter int stepDiv = `PT_STEP_DIV // tile movement divider, shared by every lane
)
(
    input wire logic clk_d,
    input wire logic rst,
    input wire pianoTilesPkg::coordT pixelX,
    input wire pianoTilesPkg::coordT pixelY,
    input wire logic active,
    input wire pianoTilesPkg::laneMaskT laneEnable, // which lanes carry a tile
    input wire pianoTilesPkg::laneMaskT buttons,
    input wire logic startButton,
    input wire logic stageChange,
    output logic [3:0] red,
    output logic [3:0] green,
    output logic [3:0] blue,
    output pianoTilesPkg::scoreT score,
    output pianoTilesPkg::gameStateT gameState
);

    pianoTilesPkg::laneMaskT inTile; // one bit from each lane
    logic tileHit;

    gameControl gameControl_i
    (
        .clk_d(clk_d),
        .rst(rst),
        .startButton(startButton),
        .stageChange(stageChange),
        .buttons(buttons),
        .inTile(inTile),
        .gameState(gameState),
        .score(score),
        .tileHit(tileHit)
    );

    // one tile per lane
    for (genvar lane = 0; lane < `PT_LANES; lane++)
    begin : gLane
        tileLane
        #(
            .laneIndex(lane),
            .stepDiv(stepDiv)
        )
        tileLane_i
        (
            .clk_d(clk_d),
            .rst(rst),
            .pixelX(pixelX),
            .pixelY(pixelY),
            .laneEnable(laneEnable[lane]),
            .stageChange(stageChange),
            .gameState(gameState),
            .inTile(inTile[lane])
        );
    end

    pixelMixer pixelMixer_i
    (
        .clk_d(clk_d),
        .rst(rst),
        .pixelX(pixelX),
        .active(active),
        .gameState(gameState),
        .inTile(inTile),
        .tileHit(tileHit),
        .red(red),
        .green(green),
        .blue(blue)
    );

endmodule

`default_nettype wire

//--- verilog/pianoTiles_params.svh
`ifndef PIANOTILES_PARAMS_SVH
`define PIANOTILES_PARAMS_SVH

// pixel counter and tile position width
`define PT_COORD_W 10
`define PT_SCORE_W 10 // up to 1023 hits

`define PT_LANES 4

// lanes repeat every 161 pixels, 157 wide, leaving a three pixel divider between them
`define PT_LANE_PITCH 161
`define PT_LANE_WIDTH 157

// bounds are exclusive on both sides: lane 0 is 0/157, lane 3 is 483/640
`define PT_LANE_X_LO(n) ((n) * `PT_LANE_PITCH)
`define PT_LANE_X_HI(n) ((n) * `PT_LANE_PITCH + `PT_LANE_WIDTH)

// number of divider gaps, gap n lies strictly between PT_LANE_X_HI(n) and PT_LANE_X_LO(n+1)
`define PT_DIV_GAPS (`PT_LANES - 1)

// tile geometry in lines
`define PT_TILE_HEIGHT 100
`define PT_SCREEN_BOTTOM 600 // tile wraps once its bottom edge passes this

// in-tile pixels scanned per one line of tile movement
`define PT_STEP_DIV 2500

// colours as 12'hRGB
`define PT_COL_LANE0 12'hA00 // dark red
`define PT_COL_LANE1 12'hFF0 // yellow
`define PT_COL_LANE2 12'h00A // dark blue
`define PT_COL_LANE3 12'h0F0 // green

`define PT_COL_DIVIDER 12'h777
`define PT_COL_TITLE 12'h333 // flat grey title screen
`define PT_COL_OVER 12'hF00 // flat red game over screen
`define PT_COL_BLACK 12'h000

`endif

//--- verilog/pixelMixer.sv
`timescale 1ns/1ns
`default_nettype none

`include "pianoTiles_params.svh"

module pixelMixer
(
    input wire logic clk_d,
    input wire logic rst,
    input wire pianoTilesPkg::coordT pixelX,
    input wire logic active, // low during blanking
    input wire pianoTilesPkg::gameStateT gameState,
    input wire pianoTilesPkg::laneMaskT inTile,
    input wire logic tileHit,
    output logic [3:0] red,
    output logic [3:0] green,
    output logic [3:0] blue
);

    // lane colours indexed by lane number
    localparam pianoTilesPkg::rgbT laneColour [0:`PT_LANES-1] =
        '{`PT_COL_LANE0, `PT_COL_LANE1, `PT_COL_LANE2, `PT_COL_LANE3};

    pianoTilesPkg::rgbT tileColour; // colour of whichever tile holds the pixel
    pianoTilesPkg::rgbT nextColour;
    pianoTilesPkg::rgbT colour; // registered output colour
    logic inGap;

    // pick the lane colour, at most one inTile bit is set
    always_comb
    begin
        tileColour = `PT_COL_BLACK;
        for (int i = 0; i < `PT_LANES; i++)
        begin
            if (inTile[i])
            begin
                tileColour = laneColour[i];
            end
        end
    end

    // grey strips between neighbouring lanes
    always_comb
    begin
        inGap = 1'b0;
        for (int n = 0; n < `PT_DIV_GAPS; n++)
        begin
            if ((pixelX > pianoTilesPkg::coordT'(`PT_LANE_X_HI(n)))
                && (pixelX < pianoTilesPkg::coordT'(`PT_LANE_X_LO(n + 1))))
            begin
                inGap = 1'b1;
            end
        end
    end

    always_comb
    begin
        nextColour = `PT_COL_BLACK;
        if (active)
        begin
            case (gameState)
                pianoTilesPkg::stTitle: nextColour = `PT_COL_TITLE;
                pianoTilesPkg::stOver: nextColour = `PT_COL_OVER;
                pianoTilesPkg::stPlaying:
                begin
                    if (|inTile)
                        nextColour = tileHit ? `PT_COL_BLACK : tileColour; // hit tiles go dark
                    else if (inGap)
                        nextColour = `PT_COL_DIVIDER;
                end
                default: nextColour = `PT_COL_BLACK;
            endcase
        end
    end

    always_ff @(posedge clk_d)
    begin
        if (rst)
            colour <= `PT_COL_BLACK;
        else
            colour <= nextColour; // one clock behind the pixel inputs
    end

    assign red = colour[11:8];
    assign green = colour[7:4];
    assign blue = colour[3:0];

endmodule

`default_nettype wire

//--- verilog/tileLane.sv
`timescale 1ns/1ns
`default_nettype none

`include "pianoTiles_params.svh"

module tileLane
#(
    parameter int laneIndex = 0, // 0 .. PT_LANES-1, picks the lane bounds
    parameter int stepDiv = `PT_STEP_DIV // in-tile pixels per one line of movement
)
(
    input wire logic clk_d,
    input wire logic rst,
    input wire pianoTilesPkg::coordT pixelX,
    input wire pianoTilesPkg::coordT pixelY,
    input wire logic laneEnable,
    input wire logic stageChange,
    input wire pianoTilesPkg::gameStateT gameState,
    output logic inTile
);

    // counter must reach stepDiv itself
    localparam int cntW = $clog2(stepDiv + 1);

    // exclusive horizontal bounds of this lane
    localparam pianoTilesPkg::coordT xLo = pianoTilesPkg::coordT'(`PT_LANE_X_LO(laneIndex));
    localparam pianoTilesPkg::coordT xHi = pianoTilesPkg::coordT'(`PT_LANE_X_HI(laneIndex));

    localparam pianoTilesPkg::coordT tileHeight = pianoTilesPkg::coordT'(`PT_TILE_HEIGHT);
    localparam pianoTilesPkg::coordT screenBottom = pianoTilesPkg::coordT'(`PT_SCREEN_BOTTOM);

    pianoTilesPkg::coordT tileTop; // first line of the tile, moves down
    pianoTilesPkg::coordT tileBottom;
    logic [cntW-1:0] stepCount; // in-tile pixels since the last move

    logic inLaneX;
    logic inTileY;
    logic pastBottom;
    logic stepDue;

    assign tileBottom = tileTop + tileHeight;

    assign inLaneX = (pixelX > xLo) && (pixelX < xHi);
    assign inTileY = (pixelY > tileTop) && (pixelY < tileBottom);

    // combinational, straight from the registered position
    assign inTile = laneEnable && inLaneX && inTileY;

    assign pastBottom = tileBottom > screenBottom;
    assign stepDue = stepCount == cntW'(stepDiv);

    always_ff @(posedge clk_d)
    begin
        if (rst)
        begin
            tileTop <= '0;
            stepCount <= '0;
        end
        else if (gameState == pianoTilesPkg::stPlaying) // frozen on title and game over
        begin
            if (pastBottom)
            begin
                // wrap back to the top and start counting afresh
                tileTop <= '0;
                stepCount <= '0;
            end
            else if (inTile)
            begin
                if (stepDue)
                begin
                    tileTop <= tileTop + pianoTilesPkg::coordT'(1); // one line down
                    stepCount <= cntW'(1); // this pixel counts toward the next step
                end
                else
                begin
                    stepCount <= stepCount + cntW'(1);
                end
            end

            if (stageChange)
            begin
                tileTop <= '0; // new stage restarts every tile, counter kept
            end
        end
    end

endmodule

`default_nettype wire
